// File: flist.f
+incdir+hw
hw/csr_reg_pkg.sv
hw/csr_exc_pkg.sv
hw/csr_except_regs.sv
hw/csr_timer.sv
hw/csr_int_ctrl.sv
hw/csr_save_regs.sv
hw/csr_read_mux.sv
hw/csr_file.sv
sim/csr_checker.sv
sim/tb_csr_file.sv

// File: hw/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

`define CSR_NUM_W       14
`define CSR_DATA_W      32

// CSR numbers
`define CSR_CRMD        14'h0000
`define CSR_PRMD        14'h0001
`define CSR_ECFG        14'h0004
`define CSR_ESTAT       14'h0005
`define CSR_ERA         14'h0006
`define CSR_BADV        14'h0007
`define CSR_EENTRY      14'h000c
`define CSR_SAVE0       14'h0030
`define CSR_SAVE1       14'h0031
`define CSR_SAVE2       14'h0032
`define CSR_SAVE3       14'h0033
`define CSR_TCFG        14'h0041
`define CSR_TVAL        14'h0042
`define CSR_TICLR       14'h0044

// Interrupt lines: 2 software, 8 hardware, 1 reserved, timer, IPI
`define CSR_INT_W       13
`define CSR_HWI_W       8

// Counter value meaning stopped
`define CSR_TIMER_IDLE  32'hffff_ffff

`endif

// File: hw/csr_exc_pkg.sv
`include "csr_defs.svh"

package csr_exc_pkg;

    localparam logic [5:0] ECODE_INT     = 6'h00;
    localparam logic [5:0] ECODE_ADE     = 6'h08;
    localparam logic [5:0] ECODE_ALE     = 6'h09;
    localparam logic [5:0] ECODE_SYS     = 6'h0b;
    localparam logic [8:0] ESUBCODE_ADEF = 9'h000;

    // Exception report from writeback
    typedef struct packed {
        logic                   ex;
        logic [5:0]             ecode;
        logic [8:0]             esubcode;
        logic [`CSR_DATA_W-1:0] pc;
        logic [`CSR_DATA_W-1:0] vaddr;
    } trap_t;

endpackage

// File: hw/csr_except_regs.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_except_regs
    import csr_reg_pkg::*;
    import csr_exc_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  csr_access_t            access,
    input  trap_t                  trap,
    input  logic                   ertn_flush,
    output crmd_t                  crmd,
    output logic [`CSR_DATA_W-1:0] era,
    output logic [`CSR_DATA_W-1:0] badv,
    output logic [`CSR_DATA_W-1:0] prmd_word,
    output logic [14:0]            estat_code,
    output logic [`CSR_DATA_W-1:0] ex_entry
);

    logic                   crmd_we;
    logic                   prmd_we;
    logic                   era_we;
    logic                   eentry_we;
    logic [1:0]             pplv;
    logic                   pie;
    logic [5:0]             ecode;
    logic [8:0]             esubcode;
    logic [25:0]            eentry_va;
    logic                   addr_err;
    csr_word_u              crmd_wr;
    logic [`CSR_DATA_W-1:0] prmd_wr;
    logic [`CSR_DATA_W-1:0] era_wr;
    logic [`CSR_DATA_W-1:0] eentry_wr;

    function automatic logic [`CSR_DATA_W-1:0] merge(input csr_access_t a,
                                                    input logic [`CSR_DATA_W-1:0] old);
        return (a.wmask & a.wvalue) | (~a.wmask & old);
    endfunction

    assign crmd_we   = access.we && access.num == `CSR_CRMD;
    assign prmd_we   = access.we && access.num == `CSR_PRMD;
    assign era_we    = access.we && access.num == `CSR_ERA;
    assign eentry_we = access.we && access.num == `CSR_EENTRY;

    assign crmd_wr.raw = merge(access, crmd);
    assign prmd_wr     = merge(access, prmd_word);
    assign era_wr      = merge(access, era);
    assign eentry_wr   = merge(access, ex_entry);

    // Trap first, then return, then software write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd    <= '0;
            crmd.da <= 1'b1;
        end else begin
            if (trap.ex) begin
                crmd.plv <= 2'd0;
                crmd.ie  <= 1'b0;
            end else if (ertn_flush) begin
                crmd.plv <= pplv;
                crmd.ie  <= pie;
            end else if (crmd_we) begin
                crmd.plv <= crmd_wr.crmd.plv;
                crmd.ie  <= crmd_wr.crmd.ie;
            end
            if (crmd_we) begin
                crmd.da   <= crmd_wr.crmd.da;
                crmd.pg   <= crmd_wr.crmd.pg;
                crmd.datf <= crmd_wr.crmd.datf;
                crmd.datm <= crmd_wr.crmd.datm;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pplv <= 2'd0;
            pie  <= 1'b0;
        end else if (trap.ex) begin
            pplv <= crmd.plv;
            pie  <= crmd.ie;
        end else if (prmd_we) begin
            pplv <= prmd_wr[1:0];
            pie  <= prmd_wr[2];
        end
    end

    assign addr_err = trap.ecode == ECODE_ADE || trap.ecode == ECODE_ALE;

    always_ff @(posedge clk) begin
        if (trap.ex) begin
            ecode    <= trap.ecode;
            esubcode <= trap.esubcode;
            era      <= trap.pc;
        end else if (era_we) begin
            era <= era_wr;
        end
        // Fetch faults report the pc itself
        if (trap.ex && addr_err) begin
            badv <= (trap.ecode == ECODE_ADE && trap.esubcode == ESUBCODE_ADEF) ?
                    trap.pc : trap.vaddr;
        end
        if (eentry_we) begin
            eentry_va <= eentry_wr[31:6];
        end
    end

    assign prmd_word  = {29'd0, pie, pplv};
    assign estat_code = {esubcode, ecode};
    assign ex_entry   = {eentry_va, 6'd0};

endmodule

// File: hw/csr_file.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_file
    import csr_reg_pkg::*;
    import csr_exc_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  csr_access_t            access,
    input  trap_t                  trap,
    input  logic                   ertn_flush,
    input  logic [`CSR_HWI_W-1:0]  hw_int,
    input  logic                   ipi_int,
    output logic [`CSR_DATA_W-1:0] rvalue,
    output logic [`CSR_DATA_W-1:0] ex_entry,
    output logic                   has_int
);

    crmd_t                  crmd;
    tcfg_t                  tcfg;
    logic [`CSR_DATA_W-1:0] era;
    logic [`CSR_DATA_W-1:0] badv;
    logic [`CSR_DATA_W-1:0] prmd_word;
    logic [`CSR_DATA_W-1:0] ecfg_word;
    logic [`CSR_DATA_W-1:0] tval;
    logic [`CSR_DATA_W-1:0] save0;
    logic [`CSR_DATA_W-1:0] save1;
    logic [`CSR_DATA_W-1:0] save2;
    logic [`CSR_DATA_W-1:0] save3;
    logic [14:0]            estat_code;
    logic [`CSR_INT_W-1:0]  estat_is;
    logic                   timer_expired;

    csr_except_regs u_except (
        .clk        (clk),
        .reset      (reset),
        .access     (access),
        .trap       (trap),
        .ertn_flush (ertn_flush),
        .crmd       (crmd),
        .era        (era),
        .badv       (badv),
        .prmd_word  (prmd_word),
        .estat_code (estat_code),
        .ex_entry   (ex_entry)
    );

    csr_timer u_timer (
        .clk     (clk),
        .reset   (reset),
        .access  (access),
        .tcfg    (tcfg),
        .tval    (tval),
        .expired (timer_expired)
    );

    csr_int_ctrl u_int (
        .clk           (clk),
        .reset         (reset),
        .access        (access),
        .hw_int        (hw_int),
        .ipi_int       (ipi_int),
        .timer_expired (timer_expired),
        .ie            (crmd.ie),
        .ecfg_word     (ecfg_word),
        .estat_is      (estat_is),
        .has_int       (has_int)
    );

    csr_save_regs u_save (
        .clk    (clk),
        .access (access),
        .save0  (save0),
        .save1  (save1),
        .save2  (save2),
        .save3  (save3)
    );

    csr_read_mux u_rmux (
        .num        (access.num),
        .crmd       (crmd),
        .prmd_word  (prmd_word),
        .ecfg_word  (ecfg_word),
        .estat_is   (estat_is),
        .estat_code (estat_code),
        .era        (era),
        .badv       (badv),
        .ex_entry   (ex_entry),
        .save0      (save0),
        .save1      (save1),
        .save2      (save2),
        .save3      (save3),
        .tcfg       (tcfg),
        .tval       (tval),
        .rvalue     (rvalue)
    );

endmodule

// File: hw/csr_int_ctrl.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_int_ctrl
    import csr_reg_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  csr_access_t            access,
    input  logic [`CSR_HWI_W-1:0]  hw_int,
    input  logic                   ipi_int,
    input  logic                   timer_expired,
    input  logic                   ie,
    output logic [`CSR_DATA_W-1:0] ecfg_word,
    output logic [`CSR_INT_W-1:0]  estat_is,
    output logic                   has_int
);

    logic                   ecfg_we;
    logic                   estat_we;
    logic                   ticlr_clr;
    logic [`CSR_INT_W-1:0]  lie;
    logic [`CSR_DATA_W-1:0] ecfg_wr;
    csr_word_u              estat_wr;

    assign ecfg_we   = access.we && access.num == `CSR_ECFG;
    assign estat_we  = access.we && access.num == `CSR_ESTAT;
    assign ticlr_clr = access.we && access.num == `CSR_TICLR &&
                       access.wmask[0] && access.wvalue[0];

    assign ecfg_wr      = (access.wmask & access.wvalue) | (~access.wmask & ecfg_word);
    assign estat_wr.raw = (access.wmask & access.wvalue) |
                          (~access.wmask & {{(`CSR_DATA_W-`CSR_INT_W){1'b0}}, estat_is});

    always_ff @(posedge clk) begin
        if (reset) begin
            lie <= '0;
        end else if (ecfg_we) begin
            lie <= ecfg_wr[`CSR_INT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_is <= '0;
        end else begin
            // Only the two software bits are writable
            if (estat_we) begin
                estat_is[1:0] <= estat_wr.estat.is[1:0];
            end
            estat_is[9:2] <= hw_int;
            estat_is[10]  <= 1'b0;
            if (timer_expired) begin
                estat_is[11] <= 1'b1;
            end else if (ticlr_clr) begin
                estat_is[11] <= 1'b0;
            end
            estat_is[12] <= ipi_int;
        end
    end

    // Bit 10 reserved, reads as zero
    assign ecfg_word = {19'd0, lie[12:11], 1'b0, lie[9:0]};
    assign has_int   = ie && |(lie & estat_is);

endmodule

// File: hw/csr_read_mux.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_read_mux (
    input  logic [`CSR_NUM_W-1:0]  num,
    input  logic [`CSR_DATA_W-1:0] crmd,
    input  logic [`CSR_DATA_W-1:0] prmd_word,
    input  logic [`CSR_DATA_W-1:0] ecfg_word,
    input  logic [`CSR_INT_W-1:0]  estat_is,
    input  logic [14:0]            estat_code,
    input  logic [`CSR_DATA_W-1:0] era,
    input  logic [`CSR_DATA_W-1:0] badv,
    input  logic [`CSR_DATA_W-1:0] ex_entry,
    input  logic [`CSR_DATA_W-1:0] save0,
    input  logic [`CSR_DATA_W-1:0] save1,
    input  logic [`CSR_DATA_W-1:0] save2,
    input  logic [`CSR_DATA_W-1:0] save3,
    input  logic [`CSR_DATA_W-1:0] tcfg,
    input  logic [`CSR_DATA_W-1:0] tval,
    output logic [`CSR_DATA_W-1:0] rvalue
);

    always_comb begin
        case (num)
            `CSR_CRMD:   rvalue = crmd;
            `CSR_PRMD:   rvalue = prmd_word;
            `CSR_ECFG:   rvalue = ecfg_word;
            `CSR_ESTAT:  rvalue = {1'b0, estat_code, 3'b000, estat_is};
            `CSR_ERA:    rvalue = era;
            `CSR_BADV:   rvalue = badv;
            `CSR_EENTRY: rvalue = {ex_entry[31:6], 6'd0};
            `CSR_SAVE0:  rvalue = save0;
            `CSR_SAVE1:  rvalue = save1;
            `CSR_SAVE2:  rvalue = save2;
            `CSR_SAVE3:  rvalue = save3;
            `CSR_TCFG:   rvalue = tcfg;
            `CSR_TVAL:   rvalue = tval;
            // TICLR and unmapped numbers read as zero
            default:     rvalue = '0;
        endcase
    end

endmodule

// File: hw/csr_reg_pkg.sv
`include "csr_defs.svh"

package csr_reg_pkg;

    typedef struct packed {
        logic [22:0] rsvd;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic        rsvd31;
        logic [8:0]  esubcode;
        logic [5:0]  ecode;
        logic [2:0]  rsvd;
        logic [12:0] is;
    } estat_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    // One CSR word, viewed per target register
    typedef union packed {
        logic [`CSR_DATA_W-1:0] raw;
        crmd_t                  crmd;
        estat_t                 estat;
        tcfg_t                  tcfg;
    } csr_word_u;

    typedef struct packed {
        logic                   we;
        logic [`CSR_NUM_W-1:0]  num;
        logic [`CSR_DATA_W-1:0] wmask;
        logic [`CSR_DATA_W-1:0] wvalue;
    } csr_access_t;

endpackage

// File: hw/csr_save_regs.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_save_regs
    import csr_reg_pkg::*;
(
    input  logic                   clk,
    input  csr_access_t            access,
    output logic [`CSR_DATA_W-1:0] save0,
    output logic [`CSR_DATA_W-1:0] save1,
    output logic [`CSR_DATA_W-1:0] save2,
    output logic [`CSR_DATA_W-1:0] save3
);

    logic [`CSR_DATA_W-1:0] save_q [4];

    // SAVE0..SAVE3 sit at consecutive numbers
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (access.we && access.num == `CSR_SAVE0 + `CSR_NUM_W'(i)) begin
                save_q[i] <= (access.wmask & access.wvalue) | (~access.wmask & save_q[i]);
            end
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

endmodule

// File: hw/csr_timer.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_timer
    import csr_reg_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  csr_access_t            access,
    output tcfg_t                  tcfg,
    output logic [`CSR_DATA_W-1:0] tval,
    output logic                   expired
);

    logic                   tcfg_we;
    csr_word_u              tcfg_wr;
    logic [`CSR_DATA_W-1:0] cnt;

    assign tcfg_we     = access.we && access.num == `CSR_TCFG;
    assign tcfg_wr.raw = (access.wmask & access.wvalue) | (~access.wmask & tcfg);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg.en <= 1'b0;
        end else if (tcfg_we) begin
            tcfg.en <= tcfg_wr.tcfg.en;
        end
        if (tcfg_we) begin
            tcfg.periodic <= tcfg_wr.tcfg.periodic;
            tcfg.initval  <= tcfg_wr.tcfg.initval;
        end
    end

    // Load uses the value being written, not the old TCFG
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= `CSR_TIMER_IDLE;
        end else if (tcfg_we && tcfg_wr.tcfg.en) begin
            cnt <= {tcfg_wr.tcfg.initval, 2'b00};
        end else if (tcfg.en && cnt != `CSR_TIMER_IDLE) begin
            if (cnt == '0 && tcfg.periodic) begin
                cnt <= {tcfg.initval, 2'b00};
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign tval    = cnt;
    assign expired = cnt == '0;

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_csr_file -f flist.f -o tb_csr_file \
    && ./obj_dir/tb_csr_file | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// File: sim/csr_checker.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_checker
    import csr_reg_pkg::*;
    import csr_exc_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  csr_access_t            access,
    input  trap_t                  trap,
    input  logic                   ertn_flush,
    input  logic [`CSR_HWI_W-1:0]  hw_int,
    input  logic                   ipi_int,
    input  logic [`CSR_DATA_W-1:0] rvalue,
    input  logic [`CSR_DATA_W-1:0] ex_entry,
    input  logic                   has_int,
    input  logic                   check_en,
    input  logic                   test_done,
    input  logic                   timer_missed,
    input  logic [8*16-1:0]        test_name,
    output int                     check_count,
    output int                     error_count,
    output int                     tests_passed,
    output int                     tests_failed
);

    // Shadow copy of the architectural state
    logic [1:0]             plv;
    logic                   ie;
    logic                   da;
    logic                   pg;
    logic [1:0]             datf;
    logic [1:0]             datm;
    logic [1:0]             pplv;
    logic                   pie;
    logic [`CSR_INT_W-1:0]  lie;
    logic [`CSR_INT_W-1:0]  pend;
    logic [5:0]             ecode;
    logic [8:0]             esubcode;
    logic [`CSR_DATA_W-1:0] era;
    logic [`CSR_DATA_W-1:0] badv;
    logic [`CSR_DATA_W-1:0] eentry;
    logic [`CSR_DATA_W-1:0] save [4];
    logic                   t_en;
    logic                   t_per;
    logic [29:0]            t_init;
    logic [`CSR_DATA_W-1:0] cnt;
    int                     test_checks;
    int                     test_errors;

    function automatic logic [`CSR_DATA_W-1:0] expected_read(input logic [`CSR_NUM_W-1:0] num);
        case (num)
            `CSR_CRMD:   return {23'd0, datm, datf, pg, da, ie, plv};
            `CSR_PRMD:   return {29'd0, pie, pplv};
            `CSR_ECFG:   return {19'd0, lie};
            `CSR_ESTAT:  return {1'b0, esubcode, ecode, 3'd0, pend};
            `CSR_ERA:    return era;
            `CSR_BADV:   return badv;
            `CSR_EENTRY: return eentry;
            `CSR_SAVE0:  return save[0];
            `CSR_SAVE1:  return save[1];
            `CSR_SAVE2:  return save[2];
            `CSR_SAVE3:  return save[3];
            `CSR_TCFG:   return {t_init, t_per, t_en};
            `CSR_TVAL:   return cnt;
            default:     return '0;
        endcase
    endfunction

    function automatic logic hit(input logic [`CSR_NUM_W-1:0] num);
        return access.we && access.num == num;
    endfunction

    always @(posedge clk) begin : shadow_update
        logic [`CSR_DATA_W-1:0] wr;
        wr = (access.wmask & access.wvalue) | (~access.wmask & expected_read(access.num));
        if (reset) begin
            plv  <= 2'd0;
            ie   <= 1'b0;
            da   <= 1'b1;
            pg   <= 1'b0;
            datf <= 2'd0;
            datm <= 2'd0;
            pplv <= 2'd0;
            pie  <= 1'b0;
            lie  <= '0;
            pend <= '0;
            t_en <= 1'b0;
            cnt  <= `CSR_TIMER_IDLE;
        end else begin
            // Trap beats return, return beats a software write
            if (trap.ex) begin
                plv      <= 2'd0;
                ie       <= 1'b0;
                pplv     <= plv;
                pie      <= ie;
                era      <= trap.pc;
                ecode    <= trap.ecode;
                esubcode <= trap.esubcode;
                if (trap.ecode == ECODE_ADE && trap.esubcode == ESUBCODE_ADEF) begin
                    badv <= trap.pc;
                end else if (trap.ecode == ECODE_ADE || trap.ecode == ECODE_ALE) begin
                    badv <= trap.vaddr;
                end
            end else if (ertn_flush) begin
                plv <= pplv;
                ie  <= pie;
            end else if (hit(`CSR_CRMD)) begin
                plv <= wr[1:0];
                ie  <= wr[2];
            end
            if (hit(`CSR_CRMD)) begin
                da   <= wr[3];
                pg   <= wr[4];
                datf <= wr[6:5];
                datm <= wr[8:7];
            end
            if (!trap.ex && hit(`CSR_PRMD)) begin
                pplv <= wr[1:0];
                pie  <= wr[2];
            end
            if (!trap.ex && hit(`CSR_ERA)) begin
                era <= wr;
            end
            // LIE bit 10 does not exist
            if (hit(`CSR_ECFG)) begin
                lie <= wr[12:0] & 13'h1bff;
            end
            if (hit(`CSR_EENTRY)) begin
                eentry <= {wr[31:6], 6'd0};
            end
            for (int i = 0; i < 4; i++) begin
                if (hit(`CSR_SAVE0 + `CSR_NUM_W'(i))) begin
                    save[i] <= wr;
                end
            end
            if (hit(`CSR_ESTAT)) begin
                pend[1:0] <= wr[1:0];
            end
            pend[9:2] <= hw_int;
            pend[10]  <= 1'b0;
            pend[12]  <= ipi_int;
            if (cnt == '0) begin
                pend[11] <= 1'b1;
            end else if (hit(`CSR_TICLR) && access.wmask[0] && access.wvalue[0]) begin
                pend[11] <= 1'b0;
            end
            if (hit(`CSR_TCFG)) begin
                t_en   <= wr[0];
                t_per  <= wr[1];
                t_init <= wr[31:2];
            end
            if (hit(`CSR_TCFG) && wr[0]) begin
                cnt <= {wr[31:2], 2'b00};
            end else if (t_en && cnt != `CSR_TIMER_IDLE) begin
                cnt <= (cnt == '0 && t_per) ? {t_init, 2'b00} : cnt - 32'd1;
            end
        end
    end

    task automatic compare_word(input string what, input logic [`CSR_DATA_W-1:0] exp,
                                input logic [`CSR_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED test %0s, %0s at csr 0x%03h: expected 0x%08h, actual 0x%08h",
                     test_name, what, access.num, exp, act);
            error_count++;
            test_errors++;
        end
    endtask

    // Outputs are stable half a cycle after the stimulus edge
    always @(negedge clk) begin : compare
        logic exp_int;
        if (reset) begin
            check_count  = 0;
            error_count  = 0;
            tests_passed = 0;
            tests_failed = 0;
            test_checks  = 0;
            test_errors  = 0;
        end else begin
            exp_int = ie && |(lie & pend);
            if (check_en) begin
                check_count++;
                test_checks++;
                compare_word("rvalue", expected_read(access.num), rvalue);
                compare_word("ex_entry", eentry, ex_entry);
                compare_word("has_int", {31'd0, exp_int}, {31'd0, has_int});
            end
            if (timer_missed) begin
                $display("Test %0s: timer interrupt bit never appeared in ESTAT in time",
                         test_name);
                error_count++;
                test_errors++;
            end
            if (test_done) begin
                if (test_errors == 0) begin
                    tests_passed++;
                    $display("Test %0s: passed, %0d checks", test_name, test_checks);
                end else begin
                    tests_failed++;
                    $display("Test %0s: failed, %0d errors in %0d checks",
                             test_name, test_errors, test_checks);
                end
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule

// File: sim/tb_csr_file.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module tb_csr_file
    import csr_reg_pkg::*;
    import csr_exc_pkg::*;
();

    localparam int RW_LOOPS   = 600;
    // Random loop takes two cycles per pass plus a few hundred for the rest
    localparam int MAX_CYCLES = 3000;

    logic                   clk;
    logic                   reset;
    csr_access_t            access;
    trap_t                  trap;
    logic                   ertn_flush;
    logic [`CSR_HWI_W-1:0]  hw_int;
    logic                   ipi_int;
    logic [`CSR_DATA_W-1:0] rvalue;
    logic [`CSR_DATA_W-1:0] ex_entry;
    logic                   has_int;
    logic                   check_en;
    logic                   test_done;
    logic                   timer_missed;
    logic [8*16-1:0]        test_name;
    int                     check_count;
    int                     error_count;
    int                     tests_passed;
    int                     tests_failed;
    integer                 seed;
    logic [`CSR_NUM_W-1:0]  rw_nums [7] = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
                                            `CSR_EENTRY, `CSR_ECFG, `CSR_PRMD};

    csr_file dut (
        .clk        (clk),
        .reset      (reset),
        .access     (access),
        .trap       (trap),
        .ertn_flush (ertn_flush),
        .hw_int     (hw_int),
        .ipi_int    (ipi_int),
        .rvalue     (rvalue),
        .ex_entry   (ex_entry),
        .has_int    (has_int)
    );

    csr_checker u_checker (
        .clk          (clk),
        .reset        (reset),
        .access       (access),
        .trap         (trap),
        .ertn_flush   (ertn_flush),
        .hw_int       (hw_int),
        .ipi_int      (ipi_int),
        .rvalue       (rvalue),
        .ex_entry     (ex_entry),
        .has_int      (has_int),
        .check_en     (check_en),
        .test_done    (test_done),
        .timer_missed (timer_missed),
        .test_name    (test_name),
        .check_count  (check_count),
        .error_count  (error_count),
        .tests_passed (tests_passed),
        .tests_failed (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_csr(input logic [`CSR_NUM_W-1:0] num, input logic [31:0] mask,
                             input logic [31:0] value);
        access = '{we: 1'b1, num: num, wmask: mask, wvalue: value};
        step_cycle();
        access.we = 1'b0;
    endtask

    task automatic read_csr(input logic [`CSR_NUM_W-1:0] num);
        access.num = num;
        check_en   = 1'b1;
        step_cycle();
        check_en   = 1'b0;
    endtask

    task automatic raise_trap(input logic [5:0] code, input logic [8:0] sub,
                              input logic [31:0] pc, input logic [31:0] vaddr);
        trap = '{ex: 1'b1, ecode: code, esubcode: sub, pc: pc, vaddr: vaddr};
        step_cycle();
        trap.ex = 1'b0;
    endtask

    task automatic return_from_trap();
        ertn_flush = 1'b1;
        step_cycle();
        ertn_flush = 1'b0;
    endtask

    task automatic finish_test();
        test_done = 1'b1;
        step_cycle();
        test_done = 1'b0;
    endtask

    // Poll ESTAT until the timer bit shows
    task automatic wait_timer_irq(input int limit);
        int   waited;
        logic seen;
        waited     = 0;
        seen       = 1'b0;
        access.num = `CSR_ESTAT;
        check_en   = 1'b1;
        while (!seen && waited < limit) begin
            @(negedge clk);
            seen = rvalue[11];
            waited++;
            step_cycle();
        end
        check_en = 1'b0;
        if (!seen) begin
            timer_missed = 1'b1;
            step_cycle();
            timer_missed = 1'b0;
        end
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : run_tests
        int idx;
        seed         = 79091;
        reset        = 1'b1;
        access       = '0;
        trap         = '0;
        ertn_flush   = 1'b0;
        hw_int       = '0;
        ipi_int      = 1'b0;
        check_en     = 1'b0;
        test_done    = 1'b0;
        timer_missed = 1'b0;
        test_name    = "init";
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // Registers without reset get known contents first
        write_csr(`CSR_EENTRY, 32'hffff_ffff, $random(seed));
        for (idx = 0; idx < 4; idx++) begin
            write_csr(`CSR_SAVE0 + `CSR_NUM_W'(idx), 32'hffff_ffff, $random(seed));
        end

        test_name = "reset";
        read_csr(`CSR_CRMD);
        read_csr(`CSR_PRMD);
        read_csr(`CSR_ECFG);
        read_csr(`CSR_TVAL);
        finish_test();

        test_name = "trap_ertn";
        write_csr(`CSR_CRMD, 32'h0000_0007, 32'h0000_0007);
        read_csr(`CSR_CRMD);
        raise_trap(ECODE_ADE, ESUBCODE_ADEF, $random(seed), $random(seed));
        read_csr(`CSR_CRMD);
        read_csr(`CSR_PRMD);
        read_csr(`CSR_ERA);
        read_csr(`CSR_ESTAT);
        read_csr(`CSR_BADV);
        return_from_trap();
        read_csr(`CSR_CRMD);
        raise_trap(ECODE_ALE, 9'd0, $random(seed), $random(seed));
        read_csr(`CSR_BADV);
        read_csr(`CSR_ESTAT);
        read_csr(`CSR_ERA);
        return_from_trap();
        raise_trap(ECODE_SYS, 9'd0, $random(seed), $random(seed));
        read_csr(`CSR_BADV);
        read_csr(`CSR_ESTAT);
        return_from_trap();
        read_csr(`CSR_CRMD);
        finish_test();

        test_name = "masked_rw";
        for (int i = 0; i < RW_LOOPS; i++) begin
            idx = $unsigned($random(seed)) % 7;
            write_csr(rw_nums[idx], $random(seed), $random(seed));
            read_csr(rw_nums[idx]);
        end
        read_csr(14'h0002);
        read_csr(14'h0100);
        read_csr(14'h3fff);
        read_csr(`CSR_TICLR);
        finish_test();

        test_name = "interrupt";
        write_csr(`CSR_ECFG, 32'hffff_ffff, 32'h0000_1004);
        write_csr(`CSR_CRMD, 32'h0000_0004, 32'h0000_0004);
        hw_int = 8'h01;
        read_csr(`CSR_ESTAT);
        read_csr(`CSR_ESTAT);
        hw_int  = 8'h00;
        ipi_int = 1'b1;
        read_csr(`CSR_ESTAT);
        read_csr(`CSR_ESTAT);
        write_csr(`CSR_CRMD, 32'h0000_0004, 32'h0000_0000);
        read_csr(`CSR_CRMD);
        write_csr(`CSR_CRMD, 32'h0000_0004, 32'h0000_0004);
        read_csr(`CSR_CRMD);
        write_csr(`CSR_ECFG, 32'h0000_1000, 32'h0000_0000);
        read_csr(`CSR_ECFG);
        ipi_int = 1'b0;
        read_csr(`CSR_ESTAT);
        finish_test();

        test_name = "timer_oneshot";
        write_csr(`CSR_TCFG, 32'hffff_ffff, {30'd5, 1'b0, 1'b1});
        wait_timer_irq(4 * 5 + 3);
        read_csr(`CSR_TVAL);
        write_csr(`CSR_TICLR, 32'h0000_0001, 32'h0000_0001);
        read_csr(`CSR_ESTAT);
        finish_test();

        test_name = "timer_periodic";
        write_csr(`CSR_TCFG, 32'hffff_ffff, {30'd4, 1'b1, 1'b1});
        wait_timer_irq(4 * 4 + 3);
        repeat (4 * 4 + 4) read_csr(`CSR_TVAL);
        write_csr(`CSR_TICLR, 32'h0000_0001, 32'h0000_0001);
        read_csr(`CSR_ESTAT);
        wait_timer_irq(4 * 4 + 3);
        write_csr(`CSR_TCFG, 32'h0000_0001, 32'h0000_0000);
        read_csr(`CSR_TCFG);
        finish_test();

        $display("Tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 tests_passed, tests_failed, check_count, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
